/* pmod_audio_top.f */
rtl/pmod_pkg.sv
rtl/codec_tdm_port.sv
rtl/channel_cal.sv
rtl/uart_byte_tx.sv
rtl/sample_uart_framer.sv
rtl/pmod_audio_top.sv
sim/tb_checker.sv
sim/tb_pmod_audio.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal --top-module tb_pmod_audio -f pmod_audio_top.f

run: compile
	./obj_dir/Vtb_pmod_audio | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

/* sim/tb_pmod_audio.sv */
/*
 * Testbench top for the CODEC audio datapath. Generates clock and reset,
 * plays the CODEC ADC side on adc_sdata and hands every sent frame to the
 * checker, which watches the DAC and UART outputs.
 */
module tb_pmod_audio;

    localparam int CYCLE_LIMIT = 60000;
    localparam int PACKETS_WANTED = 20;
    localparam int FRAMES_WANTED = 40;

    logic        clk_24mhz;
    logic        arst_n;
    logic        adc_sdata;
    logic        bick;
    logic        lrck;
    logic        dac_sdata;
    logic        uart_txd;
    logic        sent_valid;
    logic [15:0] sent_word0, sent_word1, sent_word2, sent_word3;
    logic        report_req;
    logic [6:0]  tcnt;
    logic [63:0] cur_bits;
    int          seed;
    int          frame_no;
    int          cycles;
    int          err_total;
    int          packets_done;
    int          dac_frames;

    pmod_audio_top UUT (
        .clk_24mhz (clk_24mhz),
        .arst_n    (arst_n),
        .adc_sdata (adc_sdata),
        .bick      (bick),
        .lrck      (lrck),
        .dac_sdata (dac_sdata),
        .uart_txd  (uart_txd)
    );

    tb_checker u_chk (
        .clk_24mhz    (clk_24mhz),
        .arst_n       (arst_n),
        .bick         (bick),
        .lrck         (lrck),
        .dac_sdata    (dac_sdata),
        .uart_txd     (uart_txd),
        .sent_valid   (sent_valid),
        .sent_word0   (sent_word0),
        .sent_word1   (sent_word1),
        .sent_word2   (sent_word2),
        .sent_word3   (sent_word3),
        .report_req   (report_req),
        .err_total    (err_total),
        .packets_done (packets_done),
        .dac_frames   (dac_frames)
    );

    always #20 clk_24mhz = ~clk_24mhz;

    // Every fourth frame is full scale, the rest random
    task automatic make_frame();
        int r0;
        int r1;
        r0 = $random(seed);
        r1 = $random(seed);
        if (frame_no % 4 == 3) begin
            cur_bits = 64'h8000_7fff_8000_7fff;
        end else begin
            cur_bits = {r0, r1};
        end
        sent_word0 = cur_bits[63:48];
        sent_word1 = cur_bits[47:32];
        sent_word2 = cur_bits[31:16];
        sent_word3 = cur_bits[15:0];
        sent_valid = 1'b1;
        frame_no++;
    endtask

    // ADC model follows the port counter in tcnt and puts out a new bit while bick is low
    always @(posedge clk_24mhz) begin
        #2;
        sent_valid = 1'b0;
        if (arst_n) begin
            tcnt = tcnt + 7'd1;
            if (tcnt == 7'd127) begin
                make_frame();
            end
            if (tcnt[0]) begin
                adc_sdata = cur_bits[63 - ((int'(tcnt) + 1) / 2) % 64];
            end
        end
    end

    initial begin
        clk_24mhz  = 1'b0;
        arst_n     = 1'b0;
        adc_sdata  = 1'b0;
        sent_valid = 1'b0;
        sent_word0 = '0;
        sent_word1 = '0;
        sent_word2 = '0;
        sent_word3 = '0;
        report_req = 1'b0;
        tcnt       = '0;
        cur_bits   = '0;
        seed       = 32'h548e9daf;
        frame_no   = 0;
        cycles     = 0;
        repeat (5) @(posedge clk_24mhz);
        #5 arst_n = 1'b1;
        // Checker counters settle on the rising edge, so look at them on the falling one
        while ((packets_done < PACKETS_WANTED || dac_frames < FRAMES_WANTED)
               && cycles < CYCLE_LIMIT) begin
            @(negedge clk_24mhz);
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: UART packets or DAC frames did not arrive in time");
            $display("Test failed");
        end else begin
            report_req = 1'b1;
            #1;
            if (err_total == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule

/* sim/tb_checker.sv */
/*
 * Checker for the audio datapath. Samples the DUT outputs on each clock
 * edge, models calibration and UART framing, and reports per test counts.
 */
module tb_checker (
    input  logic        clk_24mhz,
    input  logic        arst_n,
    input  logic        bick,
    input  logic        lrck,
    input  logic        dac_sdata,
    input  logic        uart_txd,
    input  logic        sent_valid,
    input  logic [15:0] sent_word0,
    input  logic [15:0] sent_word1,
    input  logic [15:0] sent_word2,
    input  logic [15:0] sent_word3,
    input  logic        report_req,
    output int          err_total,
    output int          packets_done,
    output int          dac_frames
);
    import pmod_pkg::*;

    localparam logic [63:0] FULL_SCALE = 64'h8000_7fff_8000_7fff;

    string       names [5] = '{"reset", "frame_timing", "dac", "saturation", "uart"};
    int          n_chk [5];
    int          n_err [5];
    logic [63:0] rec_q [$];
    int          pub_t [$];
    int          tcy, ec, cyc_num, rst_cyc, off;
    logic [63:0] dac_sh;
    logic        rx_busy;
    int          rx_start;
    logic [7:0]  rx_byte;
    logic [7:0]  rx_msb;
    int          pk_pos, pk_start, prev_end, exp_ch;

    initial begin
        // Words visible before the first publish are zero
        rec_q.push_back('0);
        err_total    = 0;
        packets_done = 0;
        dac_frames   = 0;
        rx_busy      = 1'b0;
        pk_pos       = 0;
        prev_end     = 0;
        exp_ch       = 0;
        rst_cyc      = 0;
        for (int t = 0; t < 5; t++) begin
            n_chk[t] = 0;
            n_err[t] = 0;
        end
    end

    // Offset, fixed point gain, floor shift and saturation
    function automatic int cal_ch(input int ch, input int x);
        longint p;
        p = longint'(x - int'(cal_offset[ch])) * longint'(cal_gain[ch]);
        p = p >>> GAIN_FRAC;
        if (p > 32767) return 32767;
        if (p < -32768) return -32768;
        return int'(p);
    endfunction

    task automatic check_val(input int t, input string what,
                             input logic [15:0] exp, input logic [15:0] act);
        n_chk[t]++;
        if (exp !== act) begin
            n_err[t]++;
            err_total++;
            $display("FAIL %s %s expected %h actual %h", names[t], what, exp, act);
        end
    endtask

    task automatic fail_plain(input int t, input string msg);
        n_chk[t]++;
        n_err[t]++;
        err_total++;
        $display("%s: %s", names[t], msg);
    endtask

    // DAC frame d carries the ADC frame published two frames earlier
    task automatic check_dac_frame(input int d);
        logic [63:0] w;
        logic [15:0] exp;
        int          t;
        w = '0;
        if (d >= 2 && d - 2 >= rec_q.size()) begin
            fail_plain(2, "DAC frame arrived without a recorded ADC frame");
        end else begin
            if (d >= 2) w = rec_q[d-2];
            t = (d >= 2 && w == FULL_SCALE) ? 3 : 2;
            for (int i = 0; i < NUM_CH; i++) begin
                exp = '0;
                if (d >= 2) begin
                    exp = 16'(cal_ch(4 + i, cal_ch(i, int'($signed(~w[63-16*i -: 16])))));
                end
                check_val(t, $sformatf("frame %0d slot %0d", d, i), exp,
                          dac_sh[63-16*i -: 16]);
            end
        end
    endtask

    // Any frame current at some point between the previous packet and this "C"
    task automatic check_uart_value(input logic [15:0] val);
        logic [15:0] base;
        logic [15:0] latest;
        logic        hit;
        base = '0;
        hit  = 1'b0;
        for (int i = 0; i < pub_t.size(); i++) begin
            if (pub_t[i] <= prev_end) begin
                base = rec_q[i][63-16*exp_ch -: 16];
            end else if (pub_t[i] <= pk_start && rec_q[i][63-16*exp_ch -: 16] == val) begin
                hit = 1'b1;
            end
        end
        latest = base;
        for (int i = 0; i < pub_t.size(); i++) begin
            if (pub_t[i] <= pk_start) latest = rec_q[i][63-16*exp_ch -: 16];
        end
        if (base == val) hit = 1'b1;
        check_val(4, $sformatf("packet %0d value", packets_done), hit ? val : latest, val);
    endtask

    task automatic byte_done(input logic [7:0] b);
        case (pk_pos)
            0: begin
                pk_start = rx_start;
                check_val(4, "byte C", 16'("C"), {8'd0, b});
            end
            1: check_val(4, "byte H", 16'("H"), {8'd0, b});
            2: check_val(4, "channel digit", 16'(8'h30 + exp_ch), {8'd0, b});
            3: rx_msb = b;
            default: begin
                check_uart_value({rx_msb, b});
                exp_ch = (exp_ch + 1) % NUM_CH;
                packets_done++;
                prev_end = tcy;
            end
        endcase
        pk_pos = (pk_pos + 1) % 5;
    endtask

    always @(posedge clk_24mhz) begin
        if (!arst_n) begin
            rst_cyc++;
            // First edge only brings the flops into reset
            if (rst_cyc > 1) begin
                check_val(0, "uart_txd", 16'd1, {15'd0, uart_txd});
                check_val(0, "dac_sdata", 16'd0, {15'd0, dac_sdata});
                check_val(0, "lrck", 16'd1, {15'd0, lrck});
            end
            tcy     = 0;
            ec      = 0;
            cyc_num = 0;
        end else begin
            if (tcy == 0) begin
                check_val(0, "uart_txd after reset", 16'd1, {15'd0, uart_txd});
                check_val(0, "dac_sdata after reset", 16'd0, {15'd0, dac_sdata});
            end
            check_val(1, "bick", {15'd0, ec % 2 == 0}, {15'd0, bick});
            check_val(1, "lrck", {15'd0, ec < FRAME_CLKS / 2}, {15'd0, lrck});
            if (sent_valid) rec_q.push_back({sent_word0, sent_word1, sent_word2, sent_word3});
            if (ec == FRAME_CLKS - 2) pub_t.push_back(tcy);
            if (ec % 2 == 0) begin
                dac_sh = {dac_sh[62:0], dac_sdata};
                if (ec == 0 && cyc_num > 0) begin
                    check_dac_frame(cyc_num - 1);
                    dac_frames++;
                end
            end
            // UART receiver samples each 24 clock bit at mid bit
            if (!rx_busy) begin
                if (!uart_txd) begin
                    rx_busy  = 1'b1;
                    rx_start = tcy;
                end
            end else begin
                off = tcy - rx_start;
                if (off == 12 && uart_txd) begin
                    fail_plain(4, "UART start bit ended early");
                    rx_busy = 1'b0;
                end else if (off >= 36 && off <= 204 && (off - 12) % 24 == 0) begin
                    rx_byte[(off - 36) / 24] = uart_txd;
                end else if (off == 228) begin
                    if (!uart_txd) fail_plain(4, "UART stop bit missing");
                    else byte_done(rx_byte);
                    rx_busy = 1'b0;
                end
            end
            ec = (ec + 1) % FRAME_CLKS;
            if (ec == 0) cyc_num++;
            tcy++;
        end
    end

    always @(posedge report_req) begin
        for (int t = 0; t < 5; t++) begin
            if (n_chk[t] == 0) begin
                err_total++;
                $display("%s: no checks ran", names[t]);
            end else begin
                $display("%s: %s, %0d checks, %0d errors", names[t],
                         n_err[t] == 0 ? "ok" : "errors", n_chk[t], n_err[t]);
            end
        end
        $display("Totals: %0d errors, %0d packets, %0d DAC frames",
                 err_total, packets_done, dac_frames);
    end

endmodule

/* rtl/pmod_audio_top.sv */
/*
 * Audio datapath top level. Connects the TDM port, the calibration
 * engine with mirror loopback, and the UART sample framer.
 */
module pmod_audio_top #(
    parameter int CLK_FREQ     = 24_000_000,
    parameter int BAUD_RATE    = 1_000_000,
    parameter bit TRANSMIT_RAW = 1'b1
) (
    input  logic clk_24mhz,
    input  logic arst_n,
    input  logic adc_sdata,
    output logic bick,
    output logic lrck,
    output logic dac_sdata,
    output logic uart_txd
);
    import pmod_pkg::*;

    sample_t    adc_word0, adc_word1, adc_word2, adc_word3;
    sample_t    cal_in0, cal_in1, cal_in2, cal_in3;
    sample_t    dac_word0, dac_word1, dac_word2, dac_word3;
    logic       sample_strobe;
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] tx_byte;

    codec_tdm_port u_port (
        .clk_24mhz     (clk_24mhz),
        .arst_n        (arst_n),
        .adc_sdata     (adc_sdata),
        .dac_word0     (dac_word0),
        .dac_word1     (dac_word1),
        .dac_word2     (dac_word2),
        .dac_word3     (dac_word3),
        .bick          (bick),
        .lrck          (lrck),
        .dac_sdata     (dac_sdata),
        .sample_strobe (sample_strobe),
        .adc_word0     (adc_word0),
        .adc_word1     (adc_word1),
        .adc_word2     (adc_word2),
        .adc_word3     (adc_word3)
    );

    channel_cal u_cal (
        .clk_24mhz     (clk_24mhz),
        .arst_n        (arst_n),
        .sample_strobe (sample_strobe),
        .adc_word0     (adc_word0),
        .adc_word1     (adc_word1),
        .adc_word2     (adc_word2),
        .adc_word3     (adc_word3),
        .cal_in0       (cal_in0),
        .cal_in1       (cal_in1),
        .cal_in2       (cal_in2),
        .cal_in3       (cal_in3),
        .dac_word0     (dac_word0),
        .dac_word1     (dac_word1),
        .dac_word2     (dac_word2),
        .dac_word3     (dac_word3)
    );

    sample_uart_framer #(
        .TRANSMIT_RAW (TRANSMIT_RAW)
    ) u_framer (
        .clk_24mhz (clk_24mhz),
        .arst_n    (arst_n),
        .raw0      (adc_word0),
        .raw1      (adc_word1),
        .raw2      (adc_word2),
        .raw3      (adc_word3),
        .cal0      (cal_in0),
        .cal1      (cal_in1),
        .cal2      (cal_in2),
        .cal3      (cal_in3),
        .tx_ready  (tx_ready),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte)
    );

    uart_byte_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_uart (
        .clk_24mhz (clk_24mhz),
        .arst_n    (arst_n),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .tx_ready  (tx_ready),
        .uart_txd  (uart_txd)
    );

endmodule

/* rtl/sample_uart_framer.sv */
/*
 * Packs one sample per channel into a five byte UART packet:
 * "C", "H", channel digit, sample MSB, sample LSB. Channels rotate 0 to 3.
 * TRANSMIT_RAW picks the raw ADC words or the calibrated inputs.
 */
module sample_uart_framer #(
    parameter bit TRANSMIT_RAW = 1'b1
) (
    input  logic              clk_24mhz,
    input  logic              arst_n,
    input  pmod_pkg::sample_t raw0,
    input  pmod_pkg::sample_t raw1,
    input  pmod_pkg::sample_t raw2,
    input  pmod_pkg::sample_t raw3,
    input  pmod_pkg::sample_t cal0,
    input  pmod_pkg::sample_t cal1,
    input  pmod_pkg::sample_t cal2,
    input  pmod_pkg::sample_t cal3,
    input  logic              tx_ready,
    output logic              tx_valid,
    output logic [7:0]        tx_byte
);
    import pmod_pkg::*;

    typedef enum logic [2:0] {
        ST_C,
        ST_H,
        ST_DIGIT,
        ST_MSB,
        ST_LSB
    } state_t;

    state_t     state;
    logic [1:0] cur_ch;
    sample_t    src [NUM_CH];
    sample_t    sample_q;

    assign src[0] = TRANSMIT_RAW ? raw0 : cal0;
    assign src[1] = TRANSMIT_RAW ? raw1 : cal1;
    assign src[2] = TRANSMIT_RAW ? raw2 : cal2;
    assign src[3] = TRANSMIT_RAW ? raw3 : cal3;

    // tx_byte always shows the byte of the current state
    always_ff @(posedge clk_24mhz or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_C;
            cur_ch   <= '0;
            tx_valid <= 1'b0;
            tx_byte  <= "C";
        end else begin
            tx_valid <= 1'b1;
            if (tx_valid && tx_ready) begin
                case (state)
                    ST_C: begin
                        tx_byte <= "H";
                        state   <= ST_H;
                    end
                    ST_H: begin
                        tx_byte <= 8'h30 + {6'd0, cur_ch};
                        state   <= ST_DIGIT;
                    end
                    ST_DIGIT: begin
                        tx_byte <= sample_q[15:8];
                        state   <= ST_MSB;
                    end
                    ST_MSB: begin
                        tx_byte <= sample_q[7:0];
                        state   <= ST_LSB;
                    end
                    default: begin
                        tx_byte <= "C";
                        state   <= ST_C;
                        if (cur_ch == 2'(NUM_CH - 1)) begin
                            cur_ch <= '0;
                        end else begin
                            cur_ch <= cur_ch + 2'd1;
                        end
                    end
                endcase
            end
        end
    end

    // Sample is frozen as the "C" goes out, so MSB and LSB match
    always_ff @(posedge clk_24mhz) begin
        if (tx_valid && tx_ready && state == ST_C) begin
            sample_q <= src[cur_ch];
        end
    end

endmodule

/* rtl/uart_byte_tx.sv */
/*
 * 8N1 UART transmitter. Takes one byte per valid/ready transfer and
 * shifts it out LSB first between a start and a stop bit.
 */
module uart_byte_tx #(
    parameter int CLK_FREQ  = 24_000_000,
    parameter int BAUD_RATE = 1_000_000
) (
    input  logic       clk_24mhz,
    input  logic       arst_n,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       tx_ready,
    output logic       uart_txd
);
    localparam int BIT_CLKS = CLK_FREQ / BAUD_RATE;
    localparam int BAUD_W = $clog2(BIT_CLKS);

    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    logic [9:0]        shift_reg;
    logic              busy;

    assign tx_ready = ~busy;
    // Idle ones are shifted in behind the frame, so the line rests high
    assign uart_txd = shift_reg[0];

    always_ff @(posedge clk_24mhz or negedge arst_n) begin
        if (!arst_n) begin
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            shift_reg <= '1;
            busy      <= 1'b0;
        end else if (!busy) begin
            if (tx_valid) begin
                shift_reg <= {1'b1, tx_byte, 1'b0};
                baud_cnt  <= '0;
                bit_cnt   <= '0;
                busy      <= 1'b1;
            end
        end else if (baud_cnt == BAUD_W'(BIT_CLKS - 1)) begin
            baud_cnt  <= '0;
            shift_reg <= {1'b1, shift_reg[9:1]};
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // The sender holds its byte until the transmitter takes it
    assert property (@(posedge clk_24mhz) disable iff (!arst_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_byte)));

endmodule

/* rtl/channel_cal.sv */
/*
 * Calibration engine. After each sample strobe it walks the four inputs
 * and then the four outputs through one shared multiplier. Outputs read
 * the freshly calibrated inputs, which gives the mirror loopback.
 */
module channel_cal (
    input  logic              clk_24mhz,
    input  logic              arst_n,
    input  logic              sample_strobe,
    input  pmod_pkg::sample_t adc_word0,
    input  pmod_pkg::sample_t adc_word1,
    input  pmod_pkg::sample_t adc_word2,
    input  pmod_pkg::sample_t adc_word3,
    output pmod_pkg::sample_t cal_in0,
    output pmod_pkg::sample_t cal_in1,
    output pmod_pkg::sample_t cal_in2,
    output pmod_pkg::sample_t cal_in3,
    output pmod_pkg::sample_t dac_word0,
    output pmod_pkg::sample_t dac_word1,
    output pmod_pkg::sample_t dac_word2,
    output pmod_pkg::sample_t dac_word3
);
    import pmod_pkg::*;

    sample_t            adc_arr [NUM_CH];
    sample_t            cal_reg [NUM_CAL_CH];
    logic [2:0]         ch_idx;
    logic               busy;
    sample_t            operand;
    logic signed [16:0] diff;
    logic signed [16:0] gain_s;
    logic signed [33:0] product;
    logic signed [33:0] scaled;
    sample_t            sat;

    assign adc_arr[0] = adc_word0;
    assign adc_arr[1] = adc_word1;
    assign adc_arr[2] = adc_word2;
    assign adc_arr[3] = adc_word3;

    // Inputs come inverted from the analog front end
    always_comb begin
        if (!ch_idx[2]) begin
            operand = ~adc_arr[ch_idx[1:0]];
        end else begin
            operand = cal_reg[{1'b0, ch_idx[1:0]}];
        end
    end

    assign diff    = 17'(operand) - 17'(cal_offset[ch_idx]);
    assign gain_s  = $signed({1'b0, cal_gain[ch_idx]});
    assign product = 34'(diff) * 34'(gain_s);
    assign scaled  = product >>> GAIN_FRAC;

    always_comb begin
        if (scaled > 34'sd32767) begin
            sat = 16'sh7fff;
        end else if (scaled < -34'sd32768) begin
            sat = 16'sh8000;
        end else begin
            sat = scaled[15:0];
        end
    end

    always_ff @(posedge clk_24mhz or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            ch_idx <= '0;
            for (int i = 0; i < NUM_CAL_CH; i++) begin
                cal_reg[i] <= '0;
            end
        end else begin
            if (busy) begin
                cal_reg[ch_idx] <= sat;
            end
            if (sample_strobe) begin
                busy   <= 1'b1;
                ch_idx <= '0;
            end else if (busy) begin
                ch_idx <= ch_idx + 3'd1;
                if (ch_idx == 3'(NUM_CAL_CH - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    assign cal_in0   = cal_reg[0];
    assign cal_in1   = cal_reg[1];
    assign cal_in2   = cal_reg[2];
    assign cal_in3   = cal_reg[3];
    assign dac_word0 = cal_reg[4];
    assign dac_word1 = cal_reg[5];
    assign dac_word2 = cal_reg[6];
    assign dac_word3 = cal_reg[7];

    // A pass must end before the port signals the next frame
    assert property (@(posedge clk_24mhz) disable iff (!arst_n)
        busy |-> !sample_strobe);

endmodule

/* rtl/codec_tdm_port.sv */
/*
 * TDM serial port towards the CODEC. Derives bick and lrck from a frame
 * counter, collects four ADC slots, sends four DAC slots and raises one
 * sample strobe per frame when fresh ADC words are available.
 */
module codec_tdm_port (
    input  logic              clk_24mhz,
    input  logic              arst_n,
    input  logic              adc_sdata,
    input  pmod_pkg::sample_t dac_word0,
    input  pmod_pkg::sample_t dac_word1,
    input  pmod_pkg::sample_t dac_word2,
    input  pmod_pkg::sample_t dac_word3,
    output logic              bick,
    output logic              lrck,
    output logic              dac_sdata,
    output logic              sample_strobe,
    output pmod_pkg::sample_t adc_word0,
    output pmod_pkg::sample_t adc_word1,
    output pmod_pkg::sample_t adc_word2,
    output pmod_pkg::sample_t adc_word3
);
    import pmod_pkg::*;

    localparam int CNT_W = $clog2(FRAME_CLKS);
    localparam int FRAME_BITS = NUM_CH * $bits(sample_t);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_CLKS - 1);
    localparam logic [CNT_W-1:0] CNT_PUBLISH = CNT_W'(FRAME_CLKS - 2);

    logic [CNT_W-1:0]      frame_cnt;
    logic [FRAME_BITS-1:0] adc_shift;
    logic [FRAME_BITS-1:0] dac_shift;

    // Two clocks per bit, lrck high for the first half of the frame
    assign bick = ~frame_cnt[0];
    assign lrck = ~frame_cnt[CNT_W-1];

    always_ff @(posedge clk_24mhz or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt     <= '0;
            adc_shift     <= '0;
            dac_shift     <= '0;
            dac_sdata     <= 1'b0;
            sample_strobe <= 1'b0;
            adc_word0     <= '0;
            adc_word1     <= '0;
            adc_word2     <= '0;
            adc_word3     <= '0;
        end else begin
            frame_cnt     <= frame_cnt + 1'b1;
            sample_strobe <= (frame_cnt == CNT_PUBLISH);

            // Odd count ends with a bick rising edge, take the ADC bit
            if (frame_cnt[0]) begin
                adc_shift <= {adc_shift[FRAME_BITS-2:0], adc_sdata};
            end

            // Slot 0 arrived first, so it sits at the top
            if (frame_cnt == CNT_PUBLISH) begin
                adc_word0 <= adc_shift[63:48];
                adc_word1 <= adc_shift[47:32];
                adc_word2 <= adc_shift[31:16];
                adc_word3 <= adc_shift[15:0];
            end

            // DAC words for the coming frame are taken on the strobe cycle
            if (frame_cnt == CNT_LAST) begin
                dac_shift <= {dac_word0, dac_word1, dac_word2, dac_word3};
            end else if (!frame_cnt[0]) begin
                // Even count ends with a bick falling edge
                dac_sdata <= dac_shift[FRAME_BITS-1];
                dac_shift <= {dac_shift[FRAME_BITS-2:0], 1'b0};
            end
        end
    end

    // Strobe is tied to the last counter value of the frame
    assert property (@(posedge clk_24mhz) disable iff (!arst_n)
        sample_strobe |-> (frame_cnt == CNT_LAST));

endmodule

/* rtl/pmod_pkg.sv */
/*
 * Shared sample type, channel counts and calibration tables for the
 * four-channel CODEC datapath. Imported by the RTL and by the checker.
 */
package pmod_pkg;

    // Signed audio word as seen by the CODEC
    typedef logic signed [15:0] sample_t;

    localparam int NUM_CH = 4;
    // Four inputs followed by four outputs
    localparam int NUM_CAL_CH = 8;
    localparam int GAIN_FRAC = 10;
    // clk_24mhz cycles per TDM frame, 24 MHz / 128 = 187.5 kHz
    localparam int FRAME_CLKS = 128;

    // Offsets in raw CODEC counts, subtracted before the gain
    localparam sample_t cal_offset [NUM_CAL_CH] = '{
        16'sd120, -16'sd85, 16'sd40, -16'sd210,
        16'sd64, -16'sd32, 16'sd150, -16'sd18
    };

    // Gains with GAIN_FRAC fraction bits, 1024 is unity
    localparam logic [15:0] cal_gain [NUM_CAL_CH] = '{
        16'd1087, 16'd998, 16'd1024, 16'd1131,
        16'd1012, 16'd1065, 16'd976, 16'd1040
    };

endpackage
